// File: files.f
+incdir+common
common/hsi_link_pkg.sv
common/hsi_tx_pkg.sv
design/byte_coder.sv
design/crc16_ccitt_calc.sv
design/crc_sender.sv
design/sdp_sender.sv
design/hsi_s_tx_ctrl/hsi_s_tx_ctrl.sv
design/hsi_s_tx.sv
tests/hsi_s_tx_tb.sv

// File: tests/hsi_s_tx_tb.sv
`timescale 1ns/100ps
`include "hsi_params.svh"

module hsi_s_tx_tb
	import hsi_link_pkg::*;
();
	localparam int N_REQ = 40; // Upper bound on requests issued by the sequence below
	localparam int N_RANDOM = 30;

	logic      clk;
	logic      n_rst;
	logic      clk_en;
	logic      en;
	hsi_flag_t rx_flag;
	logic      rx_frame_end;
	logic      rx_err;
	hsi_byte_t status;
	hsi_byte_t sd_d;
	logic      sd_d_valid;
	logic      sd_d_last;
	logic      sd_d_ready;
	logic      dat;
	logic      tx_busy;

	hsi_byte_t store_bytes[$]; // Payload the packet store offers for the next data request
	int        store_gaps[$];  // Ready cycles held back before each payload byte
	int        store_idx;
	int        gap_left;
	logic      store_xfer;
	hsi_byte_t rx_bytes[$];    // Bytes rebuilt from the serial line
	hsi_byte_t last_frame[$];
	int        value_errors;
	int        other_errors;

	hsi_s_tx UUT (
		.clk(clk),
		.n_rst(n_rst),
		.clk_en(clk_en),
		.en(en),
		.rx_flag(rx_flag),
		.rx_frame_end(rx_frame_end),
		.rx_err(rx_err),
		.status(status),
		.sd_d(sd_d),
		.sd_d_valid(sd_d_valid),
		.sd_d_last(sd_d_last),
		.sd_d_ready(sd_d_ready),
		.dat(dat),
		.tx_busy(tx_busy)
	);

	task automatic check_byte(input string name, input hsi_byte_t got, input hsi_byte_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
			value_errors++;
		end
	endtask

	task automatic check_crc(input string name, input hsi_crc_t got, input hsi_crc_t exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
			value_errors++;
		end
	endtask

	// Serial CRC-16/CCITT model that shifts in one message bit at a time with the MSB first
	function automatic hsi_crc_t model_crc(input hsi_byte_t bytes[$]);
		hsi_crc_t c;
		logic     fb;
		c = `CRC16_INIT;
		foreach (bytes[i])
		begin
			for (int b = 7; b >= 0; b--)
			begin
				fb = c[15] ^ bytes[i][b];
				c = {c[14:0], 1'b0};
				if (fb)
					c = c ^ `CRC16_POLY;
			end
		end
		return c;
	endfunction

	task automatic random_payload(output hsi_byte_t q[$]);
		int len;
		len = $urandom_range(1, 8);
		q.delete();
		repeat (len)
			q.push_back(8'($urandom));
	endtask

	task automatic send_request(input hsi_flag_t f, input logic err, input hsi_byte_t stat);
		@(negedge clk);
		rx_flag = f;
		rx_err = err;
		status = stat;
		rx_frame_end = 1'b1;
		@(negedge clk);
		rx_frame_end = 1'b0;
		rx_err = 1'b0;
	endtask

	task automatic expect_silence(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			check_flag("tx_busy", tx_busy, 1'b0);
			check_flag("dat", dat, 1'b1);
			check_flag("sd_d_ready", sd_d_ready, 1'b0);
		end
		if (rx_bytes.size() != 0)
		begin
			$display("Line carried %0d bytes while no frame was expected", rx_bytes.size());
			other_errors++;
			rx_bytes.delete();
		end
	endtask

	task automatic ignored_request(input hsi_flag_t f, input logic err);
		@(posedge clk);
		rx_bytes.delete();
		send_request(f, err, 8'($urandom));
		expect_silence(60);
	endtask

	task automatic run_frame(input hsi_flag_t f, input hsi_byte_t stat, input hsi_byte_t payload[$],
			input bit gaps, input bit poke);
		hsi_byte_t exp[$];
		hsi_crc_t  crc;
		int        cycles;
		int        n;
		logic      is_data;
		is_data = (f == `FLAG_DATA_PACKET_REQUEST);
		exp.push_back(f);
		if (is_data)
		begin
			foreach (payload[i])
				exp.push_back(payload[i]);
		end
		else
			exp.push_back(stat);
		crc = model_crc(exp);
		@(posedge clk); // Store is loaded away from the edge where it drives
		rx_bytes.delete();
		store_bytes.delete();
		store_gaps.delete();
		if (is_data)
		begin
			foreach (payload[i])
			begin
				store_bytes.push_back(payload[i]);
				store_gaps.push_back(gaps ? $urandom_range(12) : 0);
			end
		end
		store_idx = 0;
		gap_left = (store_gaps.size() > 0) ? store_gaps[0] : 0;
		send_request(f, 1'b0, stat);
		check_flag("tx_busy", tx_busy, 1'b1);
		cycles = 0;
		while (tx_busy === 1'b1)
		begin
			@(negedge clk);
			cycles++;
			if (!is_data)
				check_flag("sd_d_ready", sd_d_ready, 1'b0);
			// Requests during the frame, its tail included, must be dropped
			if (poke && cycles % 30 == 0 && tx_busy === 1'b1)
			begin
				rx_flag = `FLAG_STATUS_REQUEST;
				rx_frame_end = 1'b1;
			end
			else
				rx_frame_end = 1'b0;
		end
		check_flag("dat", dat, 1'b1);
		n = rx_bytes.size();
		if (n != exp.size() + 2)
		begin
			$display("Frame for flag 0x%h had %0d bytes instead of %0d", f, n, exp.size() + 2);
			other_errors++;
		end
		else
		begin
			foreach (exp[i])
				check_byte($sformatf("frame byte %0d", i), rx_bytes[i], exp[i]);
			check_crc("frame crc", {rx_bytes[n-2], rx_bytes[n-1]}, crc);
		end
		last_frame = rx_bytes;
		rx_bytes.delete();
		expect_silence(poke ? 60 : 4);
	endtask

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	initial
	begin : strobe_gen
		int phase;
		phase = 0;
		clk_en = 1'b0;
		forever
		begin
			@(negedge clk);
			phase = (phase + 1) % 4;
			clk_en = (phase == 0); // One bit period is four clocks
		end
	end

	// Packet store model holds each byte with valid until the DUT takes it
	initial
	begin : packet_store
		sd_d = '0;
		sd_d_valid = 1'b0;
		sd_d_last = 1'b0;
		store_idx = 0;
		gap_left = 0;
		store_xfer = 1'b0;
		forever
		begin
			@(negedge clk);
			if (store_xfer)
			begin
				store_idx++;
				gap_left = (store_idx < store_gaps.size()) ? store_gaps[store_idx] : 0;
			end
			if (store_idx < store_bytes.size() && gap_left == 0)
			begin
				sd_d_valid = 1'b1;
				sd_d = store_bytes[store_idx];
				sd_d_last = (store_idx == store_bytes.size() - 1);
			end
			else
			begin
				if (gap_left > 0 && sd_d_ready)
					gap_left--; // A gap only counts while the coder could take a byte
				sd_d_valid = 1'b0;
				sd_d_last = 1'b0;
			end
			store_xfer = sd_d_valid && sd_d_ready; // Ready does not depend on valid
		end
	end

	// Line decoder takes one sample per bit after the strobe edge has moved the line
	initial
	begin : line_decoder
		logic      was_en;
		int        bit_cnt;
		hsi_byte_t shreg;
		bit_cnt = 0;
		shreg = '0;
		forever
		begin
			@(posedge clk);
			was_en = clk_en;
			@(negedge clk);
			if (was_en && n_rst)
			begin
				if (bit_cnt == 0)
				begin
					if (dat == 1'b0)
						bit_cnt = 1;
				end
				else if (bit_cnt <= 8)
				begin
					shreg[bit_cnt-1] = dat;
					bit_cnt++;
				end
				else
				begin
					check_flag("stop bit", dat, 1'b1);
					rx_bytes.push_back(shreg);
					bit_cnt = 0;
				end
			end
		end
	end

	initial
	begin : watchdog
		#(N_REQ * (8 + 4) * `SYMBOL_BITS * 4 * 10 * 2);
		$display("Watchdog expired before the test sequence completed");
		$display("Finished with errors");
		$finish;
	end

	initial
	begin : main_seq
		hsi_byte_t payload[$];
		hsi_byte_t none[$];
		hsi_byte_t first_frame[$];
		hsi_flag_t f;
		int        pick;
		void'($urandom(24446));
		value_errors = 0;
		other_errors = 0;
		n_rst = 1'b0;
		en = 1'b1;
		rx_flag = '0;
		rx_frame_end = 1'b0;
		rx_err = 1'b0;
		status = '0;
		repeat (8)
			@(posedge clk);
		@(negedge clk);
		n_rst = 1'b1;
		expect_silence(10);

		random_payload(payload);
		run_frame(`FLAG_DATA_PACKET_REQUEST, 8'($urandom), payload, 1'b0, 1'b0);
		first_frame = last_frame;
		run_frame(`FLAG_DATA_PACKET_REQUEST, 8'($urandom), payload, 1'b1, 1'b0);
		if (first_frame.size() != last_frame.size())
		begin
			$display("Stream with gaps gave a frame of a different length");
			other_errors++;
		end
		else
		begin
			foreach (first_frame[i])
				check_byte($sformatf("gapped byte %0d", i), last_frame[i], first_frame[i]);
		end

		run_frame(`FLAG_STATUS_REQUEST, 8'($urandom), none, 1'b0, 1'b0);
		run_frame(`FLAG_CONTROL_COMMAND_WORD, 8'($urandom), none, 1'b0, 1'b0);
		ignored_request(8'($urandom_range(4, 255)), 1'b0);
		ignored_request(`FLAG_STATUS_REQUEST, 1'b1);
		ignored_request(`FLAG_DATA_PACKET_REQUEST, 1'b1);
		random_payload(payload);
		run_frame(`FLAG_DATA_PACKET_REQUEST, 8'($urandom), payload, 1'b1, 1'b1);

		repeat (N_RANDOM)
		begin
			pick = $urandom_range(5);
			f = 8'($urandom_range(1, 3));
			case (pick)
				0, 1:
				begin
					random_payload(payload);
					run_frame(`FLAG_DATA_PACKET_REQUEST, 8'($urandom), payload,
						1'($urandom), 1'b0);
				end
				2:
					run_frame(`FLAG_STATUS_REQUEST, 8'($urandom), none, 1'b0, 1'b0);
				3:
					run_frame(`FLAG_CONTROL_COMMAND_WORD, 8'($urandom), none, 1'b0, 1'b0);
				4:
					ignored_request(8'($urandom_range(4, 255)), 1'b0);
				default:
					ignored_request(f, 1'b1); // Known flag, but the frame had an error
			endcase
		end

		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: design/hsi_s_tx.sv
`timescale 1ns/100ps

module hsi_s_tx
	import hsi_link_pkg::*;
	import hsi_tx_pkg::*;
(
	input  logic      clk,
	input  logic      n_rst,
	input  logic      clk_en,
	input  logic      en,
	input  hsi_flag_t rx_flag,
	input  logic      rx_frame_end,
	input  logic      rx_err,
	input  hsi_byte_t status,
	input  hsi_byte_t sd_d,
	input  logic      sd_d_valid,
	input  logic      sd_d_last,
	output logic      sd_d_ready,
	output logic      dat,
	output logic      tx_busy
);
	logic          start;
	payload_kind_t kind;
	hsi_flag_t     flag;
	hsi_byte_t     sdp_byte;
	logic          sdp_valid;
	logic          sdp_ready;
	logic          sdp_end;
	logic          crc_start;
	hsi_byte_t     crc_byte;
	logic          crc_valid;
	logic          crc_ready;
	logic          crc_end;
	hsi_byte_t     tx_byte;
	logic          tx_valid;
	logic          tx_ready;
	logic          tx_xfer;
	logic          coder_idle;
	hsi_crc_t      crc;

	assign tx_xfer = tx_valid & tx_ready; // Every byte the coder takes goes into the CRC

	hsi_s_tx_ctrl u_ctrl (
		.clk(clk),
		.n_rst(n_rst),
		.en(en),
		.rx_frame_end(rx_frame_end),
		.rx_err(rx_err),
		.rx_flag(rx_flag),
		.start(start),
		.kind(kind),
		.flag(flag),
		.sdp_byte(sdp_byte),
		.sdp_valid(sdp_valid),
		.sdp_end(sdp_end),
		.sdp_ready(sdp_ready),
		.crc_start(crc_start),
		.crc_byte(crc_byte),
		.crc_valid(crc_valid),
		.crc_end(crc_end),
		.crc_ready(crc_ready),
		.tx_byte(tx_byte),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.coder_idle(coder_idle),
		.tx_busy(tx_busy)
	);

	sdp_sender u_sdp (
		.clk(clk),
		.n_rst(n_rst),
		.start(start),
		.kind(kind),
		.flag(flag),
		.status(status),
		.sd_d(sd_d),
		.sd_d_valid(sd_d_valid),
		.sd_d_last(sd_d_last),
		.sd_d_ready(sd_d_ready),
		.q(sdp_byte),
		.q_valid(sdp_valid),
		.q_ready(sdp_ready),
		.msg_end(sdp_end)
	);

	crc_sender u_crc_tx (
		.clk(clk),
		.n_rst(n_rst),
		.crc_start(crc_start),
		.crc(crc),
		.q(crc_byte),
		.q_valid(crc_valid),
		.q_ready(crc_ready),
		.msg_end(crc_end)
	);

	crc16_ccitt_calc u_crc_calc (
		.clk(clk),
		.n_rst(n_rst),
		.clear(start),
		.d(tx_byte),
		.d_en(tx_xfer),
		.crc(crc)
	);

	byte_coder u_coder (
		.clk(clk),
		.n_rst(n_rst),
		.clk_en(clk_en),
		.d(tx_byte),
		.d_valid(tx_valid),
		.d_ready(tx_ready),
		.q(dat),
		.idle(coder_idle)
	);

endmodule

// File: design/hsi_s_tx_ctrl/hsi_s_tx_ctrl.sv
`timescale 1ns/100ps
`include "hsi_params.svh"

module hsi_s_tx_ctrl
	import hsi_link_pkg::*;
	import hsi_tx_pkg::*;
(
	input  logic          clk,
	input  logic          n_rst,
	input  logic          en,
	input  logic          rx_frame_end,
	input  logic          rx_err,
	input  hsi_flag_t     rx_flag,
	output logic          start,
	output payload_kind_t kind,
	output hsi_flag_t     flag,
	input  hsi_byte_t     sdp_byte,
	input  logic          sdp_valid,
	input  logic          sdp_end,
	output logic          sdp_ready,
	output logic          crc_start,
	input  hsi_byte_t     crc_byte,
	input  logic          crc_valid,
	input  logic          crc_end,
	output logic          crc_ready,
	output hsi_byte_t     tx_byte,
	output logic          tx_valid,
	input  logic          tx_ready,
	input  logic          coder_idle,
	output logic          tx_busy
);
	tx_state_t state;
	logic      known_flag;
	logic      sdp_done;
	logic      crc_done;

	// Request decode
	always_comb
	begin
		known_flag = 1'b1;
		kind = PL_STATUS;
		case (rx_flag)
			`FLAG_CONTROL_COMMAND_WORD,
			`FLAG_STATUS_REQUEST:
				kind = PL_STATUS;
			`FLAG_DATA_PACKET_REQUEST:
				kind = PL_DATA;
			default:
				known_flag = 1'b0;
		endcase
	end

	assign flag = rx_flag;
	assign start = en & rx_frame_end & ~rx_err & known_flag & ~tx_busy & (state == TX_IDLE);

	assign sdp_done = sdp_valid & sdp_ready & sdp_end; // Last payload byte taken by the coder
	assign crc_done = crc_valid & crc_ready & crc_end;

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			state <= TX_IDLE;
			crc_start <= 1'b0;
		end
		else
		begin
			crc_start <= 1'b0;
			if (en)
			begin
				case (state)
					TX_IDLE:
						if (start)
							state <= TX_SDP;
					TX_SDP:
						if (sdp_done)
						begin
							state <= TX_CRC;
							crc_start <= 1'b1; // CRC register holds the final value next cycle
						end
					TX_CRC:
						if (crc_done)
							state <= TX_IDLE;
					default:
						state <= TX_IDLE;
				endcase
			end
		end
	end

	// Busy covers the tail of the frame still shifting out of the coder
	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			tx_busy <= 1'b0;
		else if (start)
			tx_busy <= 1'b1;
		else if (state == TX_IDLE && coder_idle)
			tx_busy <= 1'b0;
	end

	// Only the source of the current phase talks to the coder
	always_comb
	begin
		tx_byte = sdp_byte;
		tx_valid = 1'b0;
		sdp_ready = 1'b0;
		crc_ready = 1'b0;
		case (state)
			TX_SDP:
			begin
				tx_valid = sdp_valid;
				sdp_ready = tx_ready;
			end
			TX_CRC:
			begin
				tx_byte = crc_byte;
				tx_valid = crc_valid;
				crc_ready = tx_ready;
			end
			default:
				tx_valid = 1'b0;
		endcase
	end

endmodule

// File: design/sdp_sender.sv
`timescale 1ns/100ps

module sdp_sender
	import hsi_link_pkg::*;
	import hsi_tx_pkg::*;
(
	input  logic          clk,
	input  logic          n_rst,
	input  logic          start,
	input  payload_kind_t kind,
	input  hsi_flag_t     flag,
	input  hsi_byte_t     status,
	input  hsi_byte_t     sd_d,
	input  logic          sd_d_valid,
	input  logic          sd_d_last,
	output logic          sd_d_ready,
	output hsi_byte_t     q,
	output logic          q_valid,
	input  logic          q_ready,
	output logic          msg_end
);
	typedef enum logic [1:0]
	{
		S_IDLE,
		S_HDR,
		S_STAT,
		S_DATA
	} sdp_phase_t;

	sdp_phase_t    phase;
	payload_kind_t kind_r;
	hsi_flag_t     flag_r;
	hsi_byte_t     status_r;
	logic          xfer;

	always_ff @(posedge clk)
	begin
		if (start)
		begin
			flag_r <= flag;
			status_r <= status; // Status is sampled once per request
		end
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			phase <= S_IDLE;
			kind_r <= PL_STATUS;
		end
		else
		begin
			case (phase)
				S_IDLE:
					if (start)
					begin
						phase <= S_HDR;
						kind_r <= kind;
					end
				S_HDR:
					if (xfer)
						phase <= (kind_r == PL_DATA) ? S_DATA : S_STAT;
				S_STAT:
					if (xfer)
						phase <= S_IDLE;
				S_DATA:
					if (xfer && sd_d_last)
						phase <= S_IDLE;
				default:
					phase <= S_IDLE;
			endcase
		end
	end

	always_comb
	begin
		case (phase)
			S_STAT:
				q = status_r;
			S_DATA:
				q = sd_d; // Stream bytes go straight through to the coder
			default:
				q = flag_r;
		endcase
	end

	assign q_valid = (phase == S_HDR) | (phase == S_STAT) | ((phase == S_DATA) & sd_d_valid);
	assign sd_d_ready = (phase == S_DATA) & q_ready;
	assign xfer = q_valid & q_ready;
	assign msg_end = xfer & ((phase == S_STAT) | ((phase == S_DATA) & sd_d_last));

endmodule

// File: design/crc_sender.sv
`timescale 1ns/100ps

module crc_sender
	import hsi_link_pkg::*;
(
	input  logic      clk,
	input  logic      n_rst,
	input  logic      crc_start,
	input  hsi_crc_t  crc,
	output hsi_byte_t q,
	output logic      q_valid,
	input  logic      q_ready,
	output logic      msg_end
);
	hsi_crc_t crc_r;
	logic     hi_valid;
	logic     lo_valid;

	always_ff @(posedge clk)
	begin
		if (crc_start)
			crc_r <= crc;
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			hi_valid <= 1'b0;
			lo_valid <= 1'b0;
		end
		else if (crc_start)
			hi_valid <= 1'b1;
		else if (hi_valid && q_ready)
		begin
			hi_valid <= 1'b0;
			lo_valid <= 1'b1; // Low byte follows the accepted high byte
		end
		else if (lo_valid && q_ready)
			lo_valid <= 1'b0;
	end

	assign q = hi_valid ? crc_r[15:8] : crc_r[7:0];
	assign q_valid = hi_valid | lo_valid;
	assign msg_end = lo_valid & q_ready;

endmodule

// File: design/crc16_ccitt_calc.sv
`timescale 1ns/100ps
`include "hsi_params.svh"

module crc16_ccitt_calc
	import hsi_link_pkg::*;
(
	input  logic      clk,
	input  logic      n_rst,
	input  logic      clear,
	input  hsi_byte_t d,
	input  logic      d_en,
	output hsi_crc_t  crc
);
	// Folds one byte in, MSB first, as eight serial shifts
	function automatic hsi_crc_t crc_next(input hsi_crc_t c_in, input hsi_byte_t b);
		hsi_crc_t c;
		c = c_in ^ {b, 8'h00};
		for (int i = 0; i < 8; i++)
		begin
			if (c[15])
				c = (c << 1) ^ `CRC16_POLY;
			else
				c = c << 1;
		end
		return c;
	endfunction

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
			crc <= `CRC16_INIT;
		else if (clear)
			crc <= `CRC16_INIT; // New frame starts from the seed
		else if (d_en)
			crc <= crc_next(crc, d);
	end

endmodule

// File: design/byte_coder.sv
`timescale 1ns/100ps
`include "hsi_params.svh"

module byte_coder
	import hsi_link_pkg::*;
(
	input  logic      clk,
	input  logic      n_rst,
	input  logic      clk_en,
	input  hsi_byte_t d,
	input  logic      d_valid,
	output logic      d_ready,
	output logic      q,
	output logic      idle
);
	localparam int CNT_W = $clog2(`SYMBOL_BITS + 1);

	logic [`SYMBOL_BITS-1:0] sh;
	logic [CNT_W-1:0]        cnt;
	logic                    busy;
	logic                    load;

	assign load = d_valid & ~busy;

	// Symbol is stop, data, start so that bit 0 leaves first
	always_ff @(posedge clk)
	begin
		if (load)
			sh <= {1'b1, d, 1'b0};
		else if (busy && clk_en)
			sh <= sh >> 1;
	end

	always_ff @(posedge clk or negedge n_rst)
	begin
		if (!n_rst)
		begin
			busy <= 1'b0;
			cnt <= '0;
			q <= 1'b1;
		end
		else if (load)
		begin
			busy <= 1'b1;
			cnt <= '0;
		end
		else if (busy && clk_en)
		begin
			if (cnt == CNT_W'(`SYMBOL_BITS))
			begin
				busy <= 1'b0; // Stop bit has had its full period
				q <= 1'b1;
			end
			else
			begin
				q <= sh[0];
				cnt <= cnt + 1'b1;
			end
		end
	end

	assign d_ready = ~busy;
	assign idle = ~busy;

endmodule

// File: common/hsi_tx_pkg.sv
package hsi_tx_pkg;

	// Frame phases of the transmitter
	typedef enum logic [1:0]
	{
		TX_IDLE,
		TX_SDP,
		TX_CRC
	} tx_state_t;

	// What follows the header byte
	typedef enum logic
	{
		PL_STATUS,
		PL_DATA
	} payload_kind_t;

endpackage

// File: common/hsi_link_pkg.sv
package hsi_link_pkg;

	// One byte as it travels over the serial link
	typedef logic [7:0] hsi_byte_t;

	// Request flag code, also used as the response header byte
	typedef logic [7:0] hsi_flag_t;

	// Running and final CRC-16 value
	typedef logic [15:0] hsi_crc_t;

endpackage

// File: common/hsi_params.svh
`ifndef HSI_PARAMS_SVH
`define HSI_PARAMS_SVH

// Request flags that the receiver hands over at the end of a frame
`define FLAG_CONTROL_COMMAND_WORD 8'h01
`define FLAG_STATUS_REQUEST       8'h02
`define FLAG_DATA_PACKET_REQUEST  8'h03

// CRC-16/CCITT without reflection or final XOR
`define CRC16_POLY 16'h1021
`define CRC16_INIT 16'hFFFF

// Start bit, eight data bits and stop bit
`define SYMBOL_BITS 10

`endif
